// ==== filelist.f ====
source/shaPkg.sv
source/minerPkg.sv
source/shaRounds.sv
source/minerControl.sv
source/minerTop.sv
tests/minerControl_props.sv
tests/minerTb.sv

// ==== Bender.yml ====
package:
  name: miner

sources:
  - files:
      - source/shaPkg.sv
      - source/minerPkg.sv
      - source/shaRounds.sv
      - source/minerControl.sv
      - source/minerTop.sv
  - target: test
    files:
      - tests/minerControl_props.sv
      - tests/minerTb.sv

// ==== tests/minerTb.sv ====
module minerTb
	import minerPkg::*;
	import shaPkg::*;
();

	localparam int randomHeaders = 4;
	localparam int plannedNonces = 4 + 8 + randomHeaders * 64 + 4 + 4 + 64;
	localparam int watchdogCycles = plannedNonces * 199 + 2000; // margin covers reset and idle gaps.

	logic clock, reset, start, busy, found, exhausted;
	blockHeader header;
	nonceValue startNonce, lastNonce, foundNonce;
	targetValue target;
	hashValue foundHash;

	logic expectFoundQ [$];
	nonceValue expectNonceQ [$];
	hashValue expectHashQ [$];
	int issuedCount = 0;
	int checkedCount = 0;
	int errorCount = 0;

	minerTop minerTop_i (
		.clock, .reset, .start, .header, .startNonce, .lastNonce, .target,
		.busy, .found, .foundNonce, .foundHash, .exhausted
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	function automatic shaWord rotr(input shaWord x, input int n);
		logic [63:0] both;
		both = {x, x} >> n;
		return both[31:0];
	endfunction

	function automatic shaDigest compressBlock(input shaDigest chainIn, input shaBlock blockIn);
		shaWord w [64];
		shaWord v [8];
		shaWord s0, s1, t1, t2;
		shaDigest result;
		for (int t = 0; t < 16; t++) w[t] = blockIn[511 - 32 * t -: 32];
		for (int t = 16; t < 64; t++) begin
			s0 = rotr(w[t - 15], 7) ^ rotr(w[t - 15], 18) ^ (w[t - 15] >> 3);
			s1 = rotr(w[t - 2], 17) ^ rotr(w[t - 2], 19) ^ (w[t - 2] >> 10);
			w[t] = w[t - 16] + s0 + w[t - 7] + s1;
		end
		for (int i = 0; i < 8; i++) v[i] = chainIn[255 - 32 * i -: 32];
		for (int t = 0; t < 64; t++) begin
			t1 = v[7] + (rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25))
				+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + shaRoundConstants[t] + w[t];
			t2 = (rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22))
				+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--) v[i] = v[i - 1];
			v[4] = v[4] + t1; // v[4] now holds the old d.
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++) begin
			result[255 - 32 * i -: 32] = chainIn[255 - 32 * i -: 32] + v[i];
		end
		return result;
	endfunction

	function automatic hashValue doubleHash(input blockHeader headerIn, input nonceValue nonce);
		blockHeader full;
		shaDigest firstDigest, secondDigest;
		hashValue result;
		full = headerIn;
		for (int i = 0; i < 4; i++) full[8 * (3 - i) +: 8] = nonce[8 * i +: 8]; // byte 76 + i.
		firstDigest = compressBlock(shaInitial, full[639:128]);
		firstDigest = compressBlock(firstDigest, {full[127:0], 1'b1, 319'd0, 64'd640});
		secondDigest = compressBlock(shaInitial, {firstDigest, 1'b1, 191'd0, 64'd256});
		for (int i = 0; i < 32; i++) result[8 * i +: 8] = secondDigest[255 - 8 * i -: 8];
		return result;
	endfunction

	function automatic void referenceSearch(input blockHeader headerIn, input nonceValue first,
		input nonceValue last, input targetValue targetIn, output logic expectFound,
		output nonceValue expectNonce, output hashValue expectHash);
		nonceValue nonce;
		hashValue hash;
		logic done;
		nonce = first;
		done = 1'b0;
		expectFound = 1'b0;
		expectNonce = last;
		expectHash = '0;
		while (!done) begin
			hash = doubleHash(headerIn, nonce);
			if (hash < targetIn) begin
				expectFound = 1'b1;
				expectNonce = nonce;
				expectHash = hash;
				done = 1'b1;
			end else if (nonce == last) begin
				done = 1'b1;
			end else begin
				nonce = nonce + 32'd1;
			end
		end
	endfunction

	function automatic blockHeader randomHeader();
		blockHeader h;
		for (int i = 0; i < 20; i++) h[32 * i +: 32] = $urandom();
		return h;
	endfunction

	task automatic stopOnFailure();
		errorCount++;
		$display("Test FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkNonce(input nonceValue expected, input nonceValue actual);
		if (actual !== expected) begin
			$display("** Error at %0t: nonce expected %h, got %h", $time, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkHash(input hashValue expected, input hashValue actual);
		if (actual !== expected) begin
			$display("** Error at %0t: hash expected %h, got %h", $time, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkOutcome(input logic expectFound, input logic foundSeen,
		input logic exhaustedSeen);
		if (foundSeen !== expectFound || exhaustedSeen !== !expectFound) begin
			$display("** Error at %0t: outcome expected found=%b, got found=%b exhausted=%b",
				$time, expectFound, foundSeen, exhaustedSeen);
			stopOnFailure();
		end
	endtask

	task automatic checkBusy(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t: busy expected %b, got %b", $time, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic pulseStart(input blockHeader h, input nonceValue first, input nonceValue last,
		input targetValue t);
		@(posedge clock);
		start <= 1'b1;
		header <= h;
		startNonce <= first;
		lastNonce <= last;
		target <= t;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic expectSearch(input blockHeader h, input nonceValue first, input nonceValue last,
		input targetValue t);
		logic expectFound;
		nonceValue expectNonce;
		hashValue expectHash;
		referenceSearch(h, first, last, t, expectFound, expectNonce, expectHash);
		expectFoundQ.push_back(expectFound);
		expectNonceQ.push_back(expectNonce);
		expectHashQ.push_back(expectHash);
		issuedCount++;
	endtask

	task automatic runSearch(input blockHeader h, input nonceValue first, input nonceValue last,
		input targetValue t);
		expectSearch(h, first, last, t);
		pulseStart(h, first, last, t);
		wait (checkedCount == issuedCount);
	endtask

	initial begin : compareResults
		logic expectFound;
		forever begin
			@(negedge clock); // outputs are settled halfway through the cycle.
			if (!reset && (found || exhausted)) begin
				if (expectFoundQ.size() == 0) begin
					$display("A result pulse came while no search was expected to finish.");
					stopOnFailure();
				end else begin
					expectFound = expectFoundQ.pop_front();
					checkOutcome(expectFound, found, exhausted);
					if (expectFound) begin
						checkNonce(expectNonceQ[0], foundNonce);
						checkHash(expectHashQ[0], foundHash);
					end
					void'(expectNonceQ.pop_front());
					void'(expectHashQ.pop_front());
					checkedCount++;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (watchdogCycles) @(posedge clock);
		$display("Timeout: the DUT gave no result within %0d clock cycles.", watchdogCycles);
		stopOnFailure();
	end

	initial begin : stimulus
		blockHeader h;
		nonceValue first, held;
		void'($urandom(32'h29c6f9e3));
		reset <= 1'b1;
		start <= 1'b0;
		header <= '0;
		startNonce <= '0;
		lastNonce <= '0;
		target <= '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		first = $urandom();
		runSearch(randomHeader(), first, first + 32'd3, '1); // the first nonce must succeed.
		first = $urandom();
		runSearch(randomHeader(), first, first + 32'd7, '0); // nothing is below zero.
		for (int i = 0; i < randomHeaders; i++) begin
			first = $urandom();
			runSearch(randomHeader(), first, first + 32'd63, {4'h0, {252{1'b1}}});
		end
		// a second start while busy must be dropped.
		h = randomHeader();
		first = $urandom();
		expectSearch(h, first, first + 32'd3, '1);
		held = expectNonceQ[$];
		pulseStart(h, first, first + 32'd3, '1);
		wait (busy === 1'b1);
		pulseStart(randomHeader(), first + 32'd100, first + 32'd103, '1);
		wait (checkedCount == issuedCount);
		repeat (20) @(negedge clock);
		checkNonce(held, foundNonce);
		checkBusy(1'b0, busy);
		// reset in the middle of a long search.
		first = $urandom();
		pulseStart(randomHeader(), first, first + 32'd63, '0);
		repeat (300) @(negedge clock);
		checkBusy(1'b1, busy);
		@(posedge clock);
		reset <= 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkBusy(1'b0, busy);
		first = $urandom();
		runSearch(randomHeader(), first, first + 32'd63, {4'h0, {252{1'b1}}});
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== tests/minerControl_props.sv ====
module minerControl_props (
	input logic clock,
	input logic reset,
	input logic busy,
	input logic found,
	input logic exhausted,
	input logic shaStart,
	input logic shaDone
);

	logic coreRunning; // the core runs from its shaStart until its shaDone.

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			coreRunning <= 1'b0;
		end else if (shaStart) begin
			coreRunning <= 1'b1;
		end else if (shaDone) begin
			coreRunning <= 1'b0;
		end
	end

	resultsExclusive: assert property (@(posedge clock) disable iff (reset)
		!(found && exhausted))
		else $error("found and exhausted are high in the same cycle");

	foundPulse: assert property (@(posedge clock) disable iff (reset)
		found |=> !found)
		else $error("found lasts longer than one cycle");

	exhaustedPulse: assert property (@(posedge clock) disable iff (reset)
		exhausted |=> !exhausted)
		else $error("exhausted lasts longer than one cycle");

	startWhileIdle: assert property (@(posedge clock) disable iff (reset)
		shaStart |-> !coreRunning)
		else $error("shaStart while the core is still running");

	busyFalls: assert property (@(posedge clock) disable iff (reset)
		(found || exhausted) |=> !busy)
		else $error("busy did not fall after the result pulse");

endmodule

bind minerControl minerControl_props minerControl_props_i (
	.clock, .reset, .busy, .found, .exhausted, .shaStart, .shaDone
);

// ==== source/minerTop.sv ====
module minerTop
	import minerPkg::*;
	import shaPkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input blockHeader header,
	input nonceValue startNonce,
	input nonceValue lastNonce,
	input targetValue target,
	output logic busy,
	output logic found,
	output nonceValue foundNonce,
	output hashValue foundHash,
	output logic exhausted
);

	logic shaStart;
	logic shaDone;
	shaBlock shaBlockIn;
	shaDigest shaChainIn;
	shaDigest shaDigestOut;

	minerControl minerControl_i (
		.clock, .reset, .start, .header, .startNonce, .lastNonce, .target,
		.busy, .found, .foundNonce, .foundHash, .exhausted,
		.shaStart, .shaBlockIn, .shaChainIn, .shaDone, .shaDigestOut
	);

	shaRounds shaRounds_i (
		.clock, .reset, .shaStart, .shaBlockIn, .shaChainIn, .shaDone, .shaDigestOut
	);

endmodule

// ==== source/minerControl.sv ====
module minerControl
	import minerPkg::*;
	import shaPkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input blockHeader header,
	input nonceValue startNonce,
	input nonceValue lastNonce,
	input targetValue target,
	output logic busy,
	output logic found,
	output nonceValue foundNonce,
	output hashValue foundHash,
	output logic exhausted,
	output logic shaStart,
	output shaBlock shaBlockIn,
	output shaDigest shaChainIn,
	input logic shaDone,
	input shaDigest shaDigestOut
);

	minerState state;
	blockHeader headerReg;
	blockHeader nonceHeader;
	nonceValue nonceReg;
	nonceValue lastNonceReg;
	targetValue targetReg;
	shaDigest midDigest;
	hashValue hashReg;
	logic accept;
	logic hashBelow;
	logic lastReached;

	assign accept = start && !busy;
	assign hashBelow = hashReg < targetReg;
	assign lastReached = nonceReg == lastNonceReg;

	always_comb begin
		nonceHeader = headerReg;
		nonceHeader[headerNonceOffset +: 32] = {<<8{nonceReg}}; // low nonce byte lands in byte 76.
	end

	always_comb begin
		case (state)
			passTwo: begin
				shaBlockIn = {nonceHeader[127:0], passTwoPadding};
				shaChainIn = midDigest;
			end
			passFinal: begin
				// the core still shows the pass-two digest in the start cycle.
				shaBlockIn = {shaDigestOut, finalPadding};
				shaChainIn = shaInitial;
			end
			default: begin
				shaBlockIn = headerReg[639:128];
				shaChainIn = shaInitial;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
			busy <= 1'b0;
			found <= 1'b0;
			exhausted <= 1'b0;
			shaStart <= 1'b0;
		end else begin
			found <= 1'b0;
			exhausted <= 1'b0;
			shaStart <= 1'b0;
			if (found || exhausted) begin
				busy <= 1'b0; // busy drops one cycle after the result pulse.
			end
			case (state)
				idle: if (accept) begin
					busy <= 1'b1;
					shaStart <= 1'b1;
					state <= passOne;
				end
				passOne: if (shaDone) begin
					shaStart <= 1'b1;
					state <= passTwo;
				end
				passTwo: if (shaDone) begin
					shaStart <= 1'b1;
					state <= passFinal;
				end
				passFinal: if (shaDone) begin
					state <= check;
				end
				check: begin
					if (hashBelow) begin
						found <= 1'b1;
						state <= idle;
					end else if (lastReached) begin
						exhausted <= 1'b1;
						state <= idle;
					end else begin
						shaStart <= 1'b1; // next nonce starts right away.
						state <= passOne;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			headerReg <= header;
			nonceReg <= startNonce;
			lastNonceReg <= lastNonce;
			targetReg <= target;
		end
		if (state == passOne && shaDone) begin
			midDigest <= shaDigestOut;
		end
		if (state == passFinal && shaDone) begin
			hashReg <= {<<8{shaDigestOut}}; // read the digest as a little-endian number.
		end
		if (state == check) begin
			if (hashBelow) begin
				foundNonce <= nonceReg;
				foundHash <= hashReg;
			end else begin
				nonceReg <= nonceReg + 32'd1;
			end
		end
	end

endmodule

// ==== source/shaRounds.sv ====
module shaRounds
	import shaPkg::*;
(
	input logic clock,
	input logic reset,
	input logic shaStart,
	input shaBlock shaBlockIn,
	input shaDigest shaChainIn,
	output logic shaDone,
	output shaDigest shaDigestOut
);

	shaWord schedule [16]; // schedule[0] is the word used by the current round.
	shaWord a, b, c, d, e, f, g, h;
	shaDigest chain;
	logic [5:0] roundIndex;
	logic running;
	shaWord temp1, temp2, nextWord;

	function automatic shaWord rotateRight(input shaWord x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	always_comb begin
		temp1 = h + (rotateRight(e, 6) ^ rotateRight(e, 11) ^ rotateRight(e, 25))
			+ ((e & f) ^ (~e & g)) + shaRoundConstants[roundIndex] + schedule[0];
		temp2 = (rotateRight(a, 2) ^ rotateRight(a, 13) ^ rotateRight(a, 22))
			+ ((a & b) ^ (a & c) ^ (b & c));
		// W[t+16] from the window W[t] .. W[t+15].
		nextWord = (rotateRight(schedule[14], 17) ^ rotateRight(schedule[14], 19)
			^ (schedule[14] >> 10))
			+ schedule[9]
			+ (rotateRight(schedule[1], 7) ^ rotateRight(schedule[1], 18) ^ (schedule[1] >> 3))
			+ schedule[0];
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			roundIndex <= '0;
			shaDone <= 1'b0;
		end else begin
			shaDone <= 1'b0;
			if (shaStart) begin
				running <= 1'b1;
				roundIndex <= '0;
			end else if (running) begin
				roundIndex <= roundIndex + 6'd1;
				if (roundIndex == 6'(shaRoundCount - 1)) begin
					running <= 1'b0;
					shaDone <= 1'b1; // the sum below is valid from here on.
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (shaStart) begin
			for (int i = 0; i < 16; i++) begin
				schedule[i] <= shaBlockIn[511 - 32 * i -: 32];
			end
			{a, b, c, d, e, f, g, h} <= shaChainIn;
			chain <= shaChainIn;
		end else if (running) begin
			for (int i = 0; i < 15; i++) begin
				schedule[i] <= schedule[i + 1];
			end
			schedule[15] <= nextWord;
			h <= g;
			g <= f;
			f <= e;
			e <= d + temp1;
			d <= c;
			c <= b;
			b <= a;
			a <= temp1 + temp2;
		end
	end

	// Final add. The registers keep their values until the next load, so the digest holds too.
	assign shaDigestOut = {
		chain[255:224] + a,
		chain[223:192] + b,
		chain[191:160] + c,
		chain[159:128] + d,
		chain[127:96] + e,
		chain[95:64] + f,
		chain[63:32] + g,
		chain[31:0] + h
	};

endmodule

// ==== source/minerPkg.sv ====
package minerPkg;

	typedef logic [639:0] blockHeader; // byte 0 is the top byte.
	typedef logic [31:0] nonceValue;
	typedef logic [255:0] hashValue;
	typedef logic [255:0] targetValue;

	// the nonce is the last field of the header.
	localparam int headerNonceOffset = 0;

	localparam int headerLengthBits = 640;
	localparam int digestLengthBits = 256;

	// the second block carries 128 header bits, so 384 bits of padding follow.
	localparam logic [383:0] passTwoPadding = {
		1'b1,
		319'b0,
		64'(headerLengthBits)
	};

	// the final block carries the 256-bit digest.
	localparam logic [255:0] finalPadding = {
		1'b1,
		191'b0,
		64'(digestLengthBits)
	};

	typedef enum logic [2:0] {
		idle,
		passOne,
		passTwo,
		passFinal,
		check
	} minerState;

endpackage

// ==== source/shaPkg.sv ====
package shaPkg;

	typedef logic [31:0] shaWord;
	typedef logic [511:0] shaBlock;
	typedef logic [255:0] shaDigest; // H0 sits in the top word.

	localparam int shaRoundCount = 64;

	localparam shaDigest shaInitial = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	localparam shaWord shaRoundConstants [shaRoundCount] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage
